//--- dv/arrow_cases.txt
# columns: clear gap extra color
# clear 1 repaints the last glyph in black, gap is idle cycles before the strobe
# extra 1 adds a second strobe while busy, color is the expected pixel colour
0 12 0 3
0 3 0 3
1 5 0 0
0 2 1 2
0 4 0 7
1 1 1 0
0 6 0 7
0 2 0 1
0 3 1 2
1 2 0 0
0 1 0 7
0 5 0 1
0 2 1 3
1 3 1 0

//--- dv/arrow_display_tb.sv
`timescale 1ns/1ps

module arrow_display_tb;

	localparam int glyph_points = 16;
	localparam int ft = screen_pkg::frame_ticks;

	logic               clk;
	logic               reset_n;
	logic               change_instruction;
	logic               clear_instruction;
	logic               plot;
	screen_pkg::pixel_t pixel;
	logic               busy;

	// one entry per line of the cases file
	int case_clear[$];
	int case_gap[$];
	int case_extra[$];
	int case_color[$];

	int exp_x[glyph_points];
	int exp_y[glyph_points];
	int exp_color;

	int cyc = 0;
	int strobe_cyc;
	int last_plot_cyc;
	int plot_count;
	bit armed; // a glyph is expected
	int budget = 0;

	arrow_display dut_i (
		.clk                (clk),
		.reset_n            (reset_n),
		.change_instruction (change_instruction),
		.clear_instruction  (clear_instruction),
		.plot               (plot),
		.pixel              (pixel),
		.busy               (busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic fail_run(input string what);
		$display("Error: at %0t ns, %s", $time, what);
		$display("Regression failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("Error: at %0t ns signal %s is %0d, expected %0d",
				$time, name, actual, expected);
			$display("Regression failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic read_cases();
		int    fd;
		int    n;
		int    c, g, e, col;
		string line;
		fd = $fopen("dv/arrow_cases.txt", "r");
		if (fd == 0)
			fail_run("cannot open dv/arrow_cases.txt");
		while (!$feof(fd))
		begin
			if ($fgets(line, fd) != 0)
			begin
				if (line.len() > 1 && line.substr(0, 0) != "#")
				begin
					n = $sscanf(line, "%d %d %d %d", c, g, e, col);
					if (n != 4)
						fail_run("malformed line in the cases file");
					case_clear.push_back(c);
					case_gap.push_back(g);
					case_extra.push_back(e);
					case_color.push_back(col);
				end
			end
		end
		$fclose(fd);
	endtask

	// expected glyph points in stem, barb a, barb b order
	task automatic build_points(input arrow_pkg::arrow_kind_t kind);
		int bx, by, sx, sy;
		int k;
		int ax, ay;
		ax = int'(screen_pkg::anchor_x);
		ay = int'(screen_pkg::anchor_y);
		bx = (kind == arrow_pkg::kind_left) ? 1 : ((kind == arrow_pkg::kind_right) ? -1 : 0);
		by = (kind == arrow_pkg::kind_up) ? 1 : ((kind == arrow_pkg::kind_down) ? -1 : 0);
		sx = (bx == 0) ? 1 : 0; // vertical arrows spread their barbs along x
		sy = 1 - sx;
		for (k = 0; k < screen_pkg::stem_len; k++)
		begin
			exp_x[k] = ax + k * bx;
			exp_y[k] = ay + k * by;
		end
		for (k = 1; k <= screen_pkg::barb_len; k++)
		begin
			exp_x[7 + k] = ax + k * (bx + sx);
			exp_y[7 + k] = ay + k * (by + sy);
			exp_x[11 + k] = ax + k * (bx - sx);
			exp_y[11 + k] = ay + k * (by - sy);
		end
	endtask

	// plot monitor samples on the falling edge
	always @(negedge clk)
	begin
		if (reset_n)
		begin
			if (!armed)
			begin
				check_value("plot", plot, 0);
				check_value("busy", busy, 0);
			end
			else if (plot)
			begin
				if (plot_count >= glyph_points)
					fail_run("more than 16 plots for one glyph");
				else
				begin
					check_value("pixel.x", int'(pixel.x), exp_x[plot_count]);
					check_value("pixel.y", int'(pixel.y), exp_y[plot_count]);
					check_value("pixel.color", int'(pixel.color), exp_color);
					if (plot_count == 0)
						check_value("first plot delay", cyc - strobe_cyc, ft + 2);
					else
						check_value("plot spacing", cyc - last_plot_cyc, ft);
					last_plot_cyc = cyc;
					plot_count = plot_count + 1;
					if (plot_count == glyph_points)
						check_value("busy", busy, 0); // falls with the last plot
					else
						check_value("busy", busy, 1);
				end
			end
		end
	end

	initial
	begin
		wait (budget > 0);
		repeat (budget) @(posedge clk);
		fail_run("watchdog expired before all cases finished");
	end

	initial
	begin
		int                     i;
		int                     total;
		arrow_pkg::arrow_kind_t kind;
		arrow_pkg::arrow_kind_t last_kind;
		change_instruction = 1'b0;
		clear_instruction = 1'b0;
		reset_n = 1'b0;
		armed = 1'b0;
		plot_count = 0;
		strobe_cyc = 0;
		last_plot_cyc = 0;
		exp_color = 0;
		last_kind = arrow_pkg::kind_up; // reset value of the picker
		kind = arrow_pkg::kind_up;

		read_cases();
		total = 3 + 3 * ft + 10;
		for (i = 0; i < case_gap.size(); i++)
			total = total + case_gap[i] + glyph_points * ft + 20;
		budget = total;

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;

		for (i = 0; i < case_gap.size(); i++)
		begin
			repeat (case_gap[i]) @(negedge clk);
			if (case_clear[i] != 0)
				kind = last_kind;
			else
			begin
				case (case_color[i])
					int'(arrow_pkg::color_up):    kind = arrow_pkg::kind_up;
					int'(arrow_pkg::color_down):  kind = arrow_pkg::kind_down;
					int'(arrow_pkg::color_left):  kind = arrow_pkg::kind_left;
					int'(arrow_pkg::color_right): kind = arrow_pkg::kind_right;
					default: fail_run("cases file holds an unknown colour");
				endcase
				last_kind = kind;
			end
			build_points(kind);
			exp_color = case_color[i];
			plot_count = 0;

			change_instruction = 1'b1;
			clear_instruction = (case_clear[i] != 0);
			strobe_cyc = cyc;
			armed = 1'b1;
			@(negedge clk);
			change_instruction = 1'b0;
			clear_instruction = 1'b0;

			if (case_extra[i] != 0)
			begin
				while (plot_count < 4)
					@(posedge clk);
				@(negedge clk);
				check_value("busy", busy, 1);
				change_instruction = 1'b1; // must be dropped
				@(negedge clk);
				change_instruction = 1'b0;
			end

			while (plot_count < glyph_points)
				@(posedge clk);
			armed = 1'b0;
		end

		repeat (3 * ft) @(negedge clk); // no stray glyph after the last one

		if (case_gap.size() > 0)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("Error: no cases were read from the cases file");
			$display("Regression failed");
			$fatal(1, "empty cases file");
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the arrow display testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module arrow_display_tb \
	-Mdir obj_dir \
	-o arrow_display_sim

status=0
output=$(./obj_dir/arrow_display_sim 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -qx "Regression passed"; then
	exit 0
fi

echo "simulation did not pass, exit status $status"
exit 1

//--- sim.f
source/screen_pkg.sv
source/arrow_pkg.sv
source/arrow_picker.sv
source/glyph_sequencer.sv
source/pixel_writer.sv
source/arrow_display.sv
dv/arrow_display_tb.sv

//--- source/arrow_display.sv
`timescale 1ns/1ps

module arrow_display (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               change_instruction,
	input  logic               clear_instruction,
	output logic               plot,
	output screen_pkg::pixel_t pixel,
	output logic               busy
);

	logic                 cmd_start;
	arrow_pkg::draw_cmd_t cmd;
	logic                 point_valid;
	arrow_pkg::stroke_t   stroke;
	arrow_pkg::step_t     step;
	arrow_pkg::draw_cmd_t cur_cmd;

	arrow_picker picker_i (
		.clk                (clk),
		.reset_n            (reset_n),
		.change_instruction (change_instruction),
		.clear_instruction  (clear_instruction),
		.busy               (busy),
		.cmd_start          (cmd_start),
		.cmd                (cmd)
	);

	glyph_sequencer sequencer_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.cmd_start   (cmd_start),
		.cmd         (cmd),
		.busy        (busy),
		.point_valid (point_valid),
		.stroke      (stroke),
		.step        (step),
		.cur_cmd     (cur_cmd)
	);

	pixel_writer writer_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.point_valid (point_valid),
		.stroke      (stroke),
		.step        (step),
		.cmd         (cur_cmd),
		.plot        (plot),
		.pixel       (pixel)
	);

endmodule

//--- source/arrow_picker.sv
`timescale 1ns/1ps

module arrow_picker (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 change_instruction,
	input  logic                 clear_instruction,
	input  logic                 busy,
	output logic                 cmd_start,
	output arrow_pkg::draw_cmd_t cmd
);

	arrow_pkg::lfsr_t       lfsr;
	arrow_pkg::arrow_kind_t last_kind; // kind of the most recent draw
	arrow_pkg::arrow_kind_t rand_kind;
	logic                   accept;

	// cmd_start covers the cycle before busy is seen
	assign accept = change_instruction && !busy && !cmd_start;

	always_comb
	begin
		if (lfsr < arrow_pkg::kind_limit_up)
			rand_kind = arrow_pkg::kind_up;
		else if (lfsr < arrow_pkg::kind_limit_down)
			rand_kind = arrow_pkg::kind_down;
		else if (lfsr < arrow_pkg::kind_limit_left)
			rand_kind = arrow_pkg::kind_left;
		else
			rand_kind = arrow_pkg::kind_right;
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			lfsr <= arrow_pkg::lfsr_seed;
			last_kind <= arrow_pkg::kind_up;
			cmd_start <= 1'b0;
		end
		else
		begin
			cmd_start <= accept;
			if (accept && !clear_instruction)
			begin
				last_kind <= rand_kind;
				lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]}; // one step per draw
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			if (clear_instruction)
				cmd <= '{kind: last_kind, clear: 1'b1}; // repaint last glyph
			else
				cmd <= '{kind: rand_kind, clear: 1'b0};
		end
	end

	a_lfsr_nonzero: assert property (@(posedge clk) disable iff (!reset_n)
		lfsr != '0);

	// sequencer must never be handed a second command mid glyph
	a_no_start_busy: assert property (@(posedge clk) disable iff (!reset_n)
		busy |-> !cmd_start);

endmodule

//--- source/arrow_pkg.sv
package arrow_pkg;

	typedef enum logic [1:0] {
		kind_up,
		kind_down,
		kind_left,
		kind_right
	} arrow_kind_t;

	// part of the glyph being drawn
	typedef enum logic [1:0] {
		stroke_stem,
		stroke_barb_a,
		stroke_barb_b
	} stroke_t;

	typedef logic [2:0] step_t;

	typedef struct packed {
		arrow_kind_t kind;
		logic        clear; // repaint in black
	} draw_cmd_t;

	typedef logic [3:0] lfsr_t;

	localparam lfsr_t lfsr_seed = 4'd14;

	// upper bounds of the random value per kind, the rest is right
	localparam lfsr_t kind_limit_up = 4'd4;
	localparam lfsr_t kind_limit_down = 4'd8;
	localparam lfsr_t kind_limit_left = 4'd12;

	localparam screen_pkg::color_t color_up = 3'd7; // white
	localparam screen_pkg::color_t color_down = 3'd1;
	localparam screen_pkg::color_t color_left = 3'd2;
	localparam screen_pkg::color_t color_right = 3'd3;

	function automatic screen_pkg::color_t kind_color(input arrow_kind_t kind);
		screen_pkg::color_t c;
		case (kind)
			kind_up:   c = color_up;
			kind_down: c = color_down;
			kind_left: c = color_left;
			default:   c = color_right;
		endcase
		return c;
	endfunction

endpackage

//--- source/glyph_sequencer.sv
`timescale 1ns/1ps

module glyph_sequencer (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 cmd_start,
	input  arrow_pkg::draw_cmd_t cmd,
	output logic                 busy,
	output logic                 point_valid,
	output arrow_pkg::stroke_t   stroke,
	output arrow_pkg::step_t     step,
	output arrow_pkg::draw_cmd_t cur_cmd
);

	localparam arrow_pkg::step_t stem_last = arrow_pkg::step_t'(screen_pkg::stem_len - 1);
	localparam arrow_pkg::step_t barb_last = arrow_pkg::step_t'(screen_pkg::barb_len);
	localparam screen_pkg::frame_count_t frame_last =
		screen_pkg::frame_count_t'(screen_pkg::frame_ticks - 1);

	screen_pkg::frame_count_t frame_cnt;
	logic                     last_point;

	// one point at the end of every frame
	assign point_valid = busy && (frame_cnt == frame_last);

	assign last_point = (stroke == arrow_pkg::stroke_barb_b) && (step == barb_last);

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			busy <= 1'b0;
			frame_cnt <= '0;
			stroke <= arrow_pkg::stroke_stem;
			step <= '0;
		end
		else if (cmd_start)
		begin
			busy <= 1'b1;
			frame_cnt <= '0;
			stroke <= arrow_pkg::stroke_stem;
			step <= '0; // stem starts at the tip
		end
		else if (busy)
		begin
			if (frame_cnt == frame_last)
				frame_cnt <= '0;
			else
				frame_cnt <= frame_cnt + 1'b1;

			if (point_valid)
			begin
				case (stroke)
					arrow_pkg::stroke_stem:
					begin
						if (step == stem_last)
						begin
							stroke <= arrow_pkg::stroke_barb_a;
							step <= 3'd1; // barbs skip the tip
						end
						else
							step <= step + 1'b1;
					end
					arrow_pkg::stroke_barb_a:
					begin
						if (step == barb_last)
						begin
							stroke <= arrow_pkg::stroke_barb_b;
							step <= 3'd1;
						end
						else
							step <= step + 1'b1;
					end
					default:
					begin
						if (last_point)
						begin
							busy <= 1'b0; // glyph complete
							stroke <= arrow_pkg::stroke_stem;
							step <= '0;
						end
						else
							step <= step + 1'b1;
					end
				endcase
			end
		end
	end

	// command held for the whole glyph
	always_ff @(posedge clk)
	begin
		if (cmd_start)
			cur_cmd <= cmd;
	end

	a_step_range: assert property (@(posedge clk) disable iff (!reset_n)
		busy |-> ((stroke == arrow_pkg::stroke_stem) ?
			(int'(step) < screen_pkg::stem_len) :
			((step != '0) && (int'(step) <= screen_pkg::barb_len))));

endmodule

//--- source/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 point_valid,
	input  arrow_pkg::stroke_t   stroke,
	input  arrow_pkg::step_t     step,
	input  arrow_pkg::draw_cmd_t cmd,
	output logic                 plot,
	output screen_pkg::pixel_t   pixel
);

	logic signed [1:0] back_x, back_y; // unit vector away from the tip
	logic signed [1:0] side_x, side_y;
	logic signed [8:0] along, lateral;
	logic signed [8:0] sum_x, sum_y;
	screen_pkg::pixel_t next_pixel;

	// unit times magnitude for a unit of -1, 0 or +1
	function automatic logic signed [8:0] scale(input logic signed [1:0] unit,
		input logic signed [8:0] mag);
		logic signed [8:0] res;
		case (unit)
			2'sd1:   res = mag;
			-2'sd1:  res = -mag;
			default: res = '0;
		endcase
		return res;
	endfunction

	always_comb
	begin
		case (cmd.kind)
			arrow_pkg::kind_up:   {back_x, back_y, side_x, side_y} = {2'sd0, 2'sd1, 2'sd1, 2'sd0};
			arrow_pkg::kind_down: {back_x, back_y, side_x, side_y} = {2'sd0, -2'sd1, 2'sd1, 2'sd0};
			arrow_pkg::kind_left: {back_x, back_y, side_x, side_y} = {2'sd1, 2'sd0, 2'sd0, 2'sd1};
			default:              {back_x, back_y, side_x, side_y} = {-2'sd1, 2'sd0, 2'sd0, 2'sd1};
		endcase
	end

	always_comb
	begin
		along = 9'(step);
		case (stroke)
			arrow_pkg::stroke_barb_a: lateral = along;  // back + side
			arrow_pkg::stroke_barb_b: lateral = -along; // back - side
			default:                  lateral = '0;
		endcase
		sum_x = $signed({1'b0, screen_pkg::anchor_x}) + scale(back_x, along)
			+ scale(side_x, lateral);
		sum_y = $signed({2'b0, screen_pkg::anchor_y}) + scale(back_y, along)
			+ scale(side_y, lateral);
		next_pixel.x = sum_x[7:0];
		next_pixel.y = sum_y[6:0];
		next_pixel.color = cmd.clear ? screen_pkg::color_black : arrow_pkg::kind_color(cmd.kind);
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			plot <= 1'b0;
		else
			plot <= point_valid; // one pulse per point
	end

	always_ff @(posedge clk)
	begin
		if (point_valid)
			pixel <= next_pixel;
	end

	// on screen before truncation
	a_on_screen: assert property (@(posedge clk) disable iff (!reset_n)
		point_valid |-> (sum_x >= 0) && (int'(sum_x) < screen_pkg::screen_width) &&
			(sum_y >= 0) && (int'(sum_y) < screen_pkg::screen_height));

endmodule

//--- source/screen_pkg.sv
package screen_pkg;

	// pixel coordinates, origin top left
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t; // y grows downward

	typedef logic [2:0] color_t; // r g b, one bit each

	typedef logic [2:0] frame_count_t;

	localparam int screen_width = 160;
	localparam int screen_height = 120;

	localparam color_t color_black = 3'd0;

	// glyph tip, roughly mid screen
	localparam coord_x_t anchor_x = 8'd79;
	localparam coord_y_t anchor_y = 7'd63;

	localparam int stem_len = 8; // stem points, tip included
	localparam int barb_len = 4; // points per barb

	// clock cycles between two plotted points
	localparam int frame_ticks = 8;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
		color_t   color;
	} pixel_t;

endpackage
